// ==== vlog.f ====
+incdir+.
armPkg.sv
armAlu.sv
regFile.sv
armDecoder.sv
condUnit.sv
armDatapath.sv
dataMem.sv
armSystem.sv
armTb.sv

// ==== Makefile ====
# Verilator build and run of the single-cycle ARM core testbench

VERILATOR ?= verilator
TOP       ?= armTb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0

SOURCES := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails when the log holds the fail message or the simulator exits with an error
run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "=== FAIL ===" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== armTbAsm.svh ====
/*
 * Instruction encoders for testbench programs: data processing,
 * word load/store and branch forms of the core's subset
 */
`ifndef ARM_TB_ASM_SVH
`define ARM_TB_ASM_SVH

// Data processing with an unrotated 8-bit immediate
function automatic logic [31:0] dpImm(input condT c, input dpOpT op, input logic s,
                                      input int rd, input int rn, input logic [7:0] imm);
  return {c, 2'b00, 1'b1, op, s, 4'(rn), 4'(rd), 4'h0, imm};
endfunction

// Data processing with an unshifted register operand
function automatic logic [31:0] dpReg(input condT c, input dpOpT op, input logic s,
                                      input int rd, input int rn, input int rm);
  return {c, 2'b00, 1'b0, op, s, 4'(rn), 4'(rd), 8'h00, 4'(rm)};
endfunction

// Word LDR/STR, pre-indexed, offset added, no writeback
function automatic logic [31:0] ldrStr(input condT c, input logic load, input int rd,
                                       input int rn, input logic [11:0] off);
  return {c, 2'b01, 5'b01100, load, 4'(rn), 4'(rd), off};
endfunction

// Branch by a signed word offset from PC+8
function automatic logic [31:0] branchRel(input condT c, input int off);
  return {c, 4'b1010, 24'(off)};
endfunction

// MOV R0, R0
function automatic logic [31:0] nopWord();
  return dpReg(condAl, dpMov, 1'b0, 0, 0, 0);
endfunction

`endif

// ==== armTb.sv ====
/*
 * Testbench for the single-cycle ARM core with fetch model, store monitor
 * and directed tests
 */
module armTb;
  timeunit 1ns;
  timeprecision 1ns;
  import armPkg::*;

  `include "armTbAsm.svh"

  localparam int halfPeriod = 50;
  localparam int maxCycles  = 200;

  logic        clk;
  logic        reset;
  instrT       instr;
  logic [31:0] pc;
  logic        memWrite;
  logic [31:0] dataAdr;
  logic [31:0] writeData;

  logic [31:0] prog [$];
  logic [31:0] gotAdr [$];
  logic [31:0] gotData [$];
  logic [31:0] expAdr [$];
  logic [31:0] expData [$];
  string       testName;
  int          testErrors;
  int          totalErrors;
  int          testCount;
  int          failedTests;

  condT condList [12] = '{condEq, condNe, condCs, condCc, condHi, condLs,
                          condGe, condLt, condGt, condLe, condMi, condPl};

  armSystem armSystem_inst (
    .clk       (clk),
    .reset     (reset),
    .instr     (instr),
    .pc        (pc),
    .memWrite  (memWrite),
    .dataAdr   (dataAdr),
    .writeData (writeData)
  );

  initial begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: %s expected %h actual %h",
               testName, what, expected, actual);
      testErrors++;
    end
  endtask

  task automatic reportError(input string msg);
    $display("Error in %s: %s", testName, msg);
    testErrors++;
  endtask

  // Unsigned and signed rules of a CMP a, b
  function automatic logic condHolds(input condT c, input logic [31:0] a,
                                     input logic [31:0] b);
    logic [31:0] diff;
    diff = a - b;
    case (c)
      condEq:  return a == b;
      condNe:  return a != b;
      condCs:  return a >= b;
      condCc:  return a < b;
      condHi:  return a > b;
      condLs:  return a <= b;
      condGe:  return $signed(a) >= $signed(b);
      condLt:  return $signed(a) < $signed(b);
      condGt:  return $signed(a) > $signed(b);
      condLe:  return $signed(a) <= $signed(b);
      condMi:  return diff[31];
      condPl:  return !diff[31];
      default: return 1'b1;
    endcase
  endfunction

  // Past the end of the program the core spins on a branch-to-self
  function automatic logic [31:0] fetchWord(input logic [31:0] adr);
    int idx;
    idx = int'(adr >> 2);
    if (idx < prog.size()) begin
      return prog[idx];
    end else begin
      return branchRel(condAl, -2);
    end
  endfunction

  task automatic startTest(input string name);
    testName   = name;
    testErrors = 0;
  endtask

  task automatic newProgram();
    prog.delete();
    expAdr.delete();
    expData.delete();
  endtask

  task automatic expectStore(input logic [31:0] adr, input logic [31:0] data);
    expAdr.push_back(adr);
    expData.push_back(data);
  endtask

  // Ends on a falling edge with reset just released
  task automatic applyReset();
    @(negedge clk);
    reset = 1'b1;
    instr = instrT'(nopWord());
    repeat (2) begin
      @(negedge clk);
      checkValue("pc in reset", 32'h0, pc);
      checkValue("memWrite in reset", 32'h0, 32'(memWrite));
    end
    reset = 1'b0;
  endtask

  // One instruction driven at the falling edge and sampled just before the rising edge
  task automatic runCycle();
    instr = instrT'(fetchWord(pc));
    #(halfPeriod - 1);
    if (memWrite) begin
      gotAdr.push_back(dataAdr);
      gotData.push_back(writeData);
    end
    @(negedge clk);
  endtask

  task automatic runProgram();
    logic [31:0] haltAdr;
    int          cycles;
    haltAdr = 32'(prog.size()) << 2;
    gotAdr.delete();
    gotData.delete();
    applyReset();
    cycles = 0;
    while (pc != haltAdr && cycles < maxCycles) begin
      runCycle();
      cycles++;
    end
    // Branch-to-self until the next reset
    instr = instrT'(fetchWord(pc));
    if (pc != haltAdr) begin
      reportError("program did not reach its end before the timeout");
    end
    if (gotAdr.size() < expAdr.size()) begin
      reportError($sformatf("too few stores appeared, %0d of %0d",
                            gotAdr.size(), expAdr.size()));
    end else if (gotAdr.size() > expAdr.size()) begin
      reportError($sformatf("%0d stores appeared where %0d were expected",
                            gotAdr.size(), expAdr.size()));
    end
    for (int i = 0; i < expAdr.size() && i < gotAdr.size(); i++) begin
      checkValue($sformatf("store %0d address", i), expAdr[i], gotAdr[i]);
      checkValue($sformatf("store %0d data", i), expData[i], gotData[i]);
    end
  endtask

  task automatic finishTest();
    testCount++;
    totalErrors += testErrors;
    if (testErrors == 0) begin
      $display("%s: ok", testName);
    end else begin
      failedTests++;
      $display("%s: %0d errors", testName, testErrors);
    end
  endtask

  task automatic testSequencing();
    startTest("sequencing");
    newProgram();
    repeat (12) prog.push_back(nopWord());
    applyReset();
    for (int i = 1; i <= 8; i++) begin
      runCycle();
      checkValue("pc", 32'(i * 4), pc);
    end
    finishTest();
  endtask

  task automatic regOpStore(input dpOpT op, input int rd, input logic [31:0] expected);
    prog.push_back(dpReg(condAl, op, 1'b0, rd, 1, 2));
    prog.push_back(ldrStr(condAl, 1'b0, rd, 0, 12'(rd * 4)));
    expectStore(32'(rd * 4), expected);
  endtask

  task automatic testArith();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    startTest("arithmetic");
    repeat (3) begin
      newProgram();
      a = $urandom & 32'hff;
      b = $urandom & 32'hff;
      c = $urandom & 32'hff;
      prog.push_back(dpImm(condAl, dpMov, 1'b0, 1, 0, a[7:0]));
      prog.push_back(dpImm(condAl, dpMov, 1'b0, 2, 0, b[7:0]));
      prog.push_back(dpImm(condAl, dpMov, 1'b0, 0, 0, 8'd0));
      regOpStore(dpAdd, 3, a + b);
      regOpStore(dpSub, 4, a - b);
      regOpStore(dpAnd, 5, a & b);
      regOpStore(dpOrr, 6, a | b);
      regOpStore(dpEor, 7, a ^ b);
      // Immediate forms where the subtract may wrap below zero
      prog.push_back(dpImm(condAl, dpAdd, 1'b0, 8, 1, c[7:0]));
      prog.push_back(ldrStr(condAl, 1'b0, 8, 0, 12'd32));
      expectStore(32'd32, a + c);
      prog.push_back(dpImm(condAl, dpSub, 1'b0, 9, 2, c[7:0]));
      prog.push_back(ldrStr(condAl, 1'b0, 9, 0, 12'd36));
      expectStore(32'd36, b - c);
      runProgram();
    end
    finishTest();
  endtask

  task automatic testConditions();
    logic [31:0] a;
    logic [31:0] b;
    startTest("conditions");
    for (int p = 0; p < 4; p++) begin
      newProgram();
      a = $urandom & 32'hff;
      b = (p == 1) ? a : ($urandom & 32'hff);
      // Last pass pairs a negative a with a positive b so the CMP overflows
      if (p == 3) begin
        a = a & 32'h3f;
        b = b | 32'hc0;
      end
      // Shift both operands into -128..127
      prog.push_back(dpImm(condAl, dpMov, 1'b0, 0, 0, 8'd0));
      prog.push_back(dpImm(condAl, dpMov, 1'b0, 1, 0, a[7:0]));
      prog.push_back(dpImm(condAl, dpSub, 1'b0, 1, 1, 8'd128));
      prog.push_back(dpImm(condAl, dpMov, 1'b0, 2, 0, b[7:0]));
      prog.push_back(dpImm(condAl, dpSub, 1'b0, 2, 2, 8'd128));
      a = a - 32'd128;
      b = b - 32'd128;
      // Doubling 24 times moves both into the top byte
      if (p == 3) begin
        repeat (24) begin
          prog.push_back(dpReg(condAl, dpAdd, 1'b0, 1, 1, 1));
          prog.push_back(dpReg(condAl, dpAdd, 1'b0, 2, 2, 2));
        end
        a = a << 24;
        b = b << 24;
      end
      prog.push_back(dpReg(condAl, dpCmp, 1'b1, 0, 1, 2));
      prog.push_back(dpReg(condAl, dpAdd, 1'b0, 3, 1, 2));
      for (int k = 0; k < 12; k++) begin
        prog.push_back(ldrStr(condList[k], 1'b0, 1, 0, 12'(k * 4)));
        if (condHolds(condList[k], a, b)) begin
          expectStore(32'(k * 4), a);
        end
      end
      runProgram();
    end
    finishTest();
  endtask

  task automatic testLoadStore();
    logic [31:0] vals [3];
    startTest("load/store");
    newProgram();
    prog.push_back(dpImm(condAl, dpMov, 1'b0, 0, 0, 8'd64));
    for (int i = 0; i < 3; i++) begin
      vals[i] = $urandom & 32'hff;
      prog.push_back(dpImm(condAl, dpMov, 1'b0, 1, 0, vals[i][7:0]));
      prog.push_back(ldrStr(condAl, 1'b0, 1, 0, 12'(i * 4)));
      expectStore(32'(64 + i * 4), vals[i]);
    end
    for (int i = 0; i < 3; i++) begin
      prog.push_back(ldrStr(condAl, 1'b1, 2, 0, 12'(i * 4)));
      prog.push_back(dpImm(condAl, dpAdd, 1'b0, 2, 2, 8'd1));
      prog.push_back(ldrStr(condAl, 1'b0, 2, 0, 12'(32 + i * 4)));
      expectStore(32'(96 + i * 4), vals[i] + 32'd1);
    end
    runProgram();
    finishTest();
  endtask

  task automatic testBranch();
    logic [31:0] n;
    startTest("branching");
    newProgram();
    n = ($urandom % 15) + 1;
    prog.push_back(dpImm(condAl, dpMov, 1'b0, 0, 0, 8'd0));
    prog.push_back(dpImm(condAl, dpMov, 1'b0, 1, 0, 8'haa));
    prog.push_back(branchRel(condAl, 0));
    prog.push_back(ldrStr(condAl, 1'b0, 1, 0, 12'd0));
    prog.push_back(dpImm(condAl, dpMov, 1'b0, 2, 0, n[7:0]));
    prog.push_back(dpImm(condAl, dpMov, 1'b0, 3, 0, 8'd0));
    // Countdown loop at word 6
    prog.push_back(dpImm(condAl, dpSub, 1'b1, 2, 2, 8'd1));
    prog.push_back(dpImm(condAl, dpAdd, 1'b0, 3, 3, 8'd1));
    prog.push_back(branchRel(condNe, -4));
    prog.push_back(ldrStr(condAl, 1'b0, 3, 0, 12'd4));
    expectStore(32'd4, n);
    prog.push_back(dpReg(condAl, dpMov, 1'b0, 4, 0, 15));
    prog.push_back(ldrStr(condAl, 1'b0, 4, 0, 12'd8));
    expectStore(32'd8, 32'd48);
    // Write to R15 jumps over the next store
    prog.push_back(dpImm(condAl, dpMov, 1'b0, 15, 0, 8'd56));
    prog.push_back(ldrStr(condAl, 1'b0, 1, 0, 12'd12));
    prog.push_back(ldrStr(condAl, 1'b0, 3, 0, 12'd16));
    expectStore(32'd16, n);
    runProgram();
    finishTest();
  endtask

  initial begin
    void'($urandom(32'h3b5f_bc8e));
    reset       = 1'b1;
    instr       = instrT'(nopWord());
    testCount   = 0;
    failedTests = 0;
    totalErrors = 0;
    testSequencing();
    testArith();
    testConditions();
    testLoadStore();
    testBranch();
    $display("tests %0d, failed %0d, errors %0d", testCount, failedTests, totalErrors);
    if (totalErrors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== armSystem.sv ====
/*
 * Single-cycle ARM core top level with external fetch port and internal
 * data memory
 */
module armSystem (
  input  logic                     clk,
  input  logic                     reset,
  input  armPkg::instrT            instr,
  output logic [armPkg::wordW-1:0] pc,
  output logic                     memWrite,
  output logic [armPkg::wordW-1:0] dataAdr,
  output logic [armPkg::wordW-1:0] writeData
);
  import armPkg::*;

  ctrlT             ctrl;
  flagsT            aluFlags;
  logic             regWriteEn;
  logic             pcSrc;
  logic             movSel;
  logic [wordW-1:0] readData;

  armDecoder armDecoder_inst (
    .op    (instr.op),
    .funct (instr.funct),
    .rd    (instr.rd),
    .ctrl  (ctrl)
  );

  condUnit condUnit_inst (
    .clk        (clk),
    .reset      (reset),
    .cond       (instr.cond),
    .ctrl       (ctrl),
    .aluFlags   (aluFlags),
    .regWriteEn (regWriteEn),
    .memWriteEn (memWrite),
    .pcSrc      (pcSrc),
    .movSel     (movSel)
  );

  armDatapath armDatapath_inst (
    .clk        (clk),
    .reset      (reset),
    .instr      (instr),
    .ctrl       (ctrl),
    .regWriteEn (regWriteEn),
    .pcSrc      (pcSrc),
    .movSel     (movSel),
    .readData   (readData),
    .pc         (pc),
    .aluResult  (dataAdr),
    .writeData  (writeData),
    .aluFlags   (aluFlags)
  );

  dataMem dataMem_inst (
    .clk  (clk),
    .we   (memWrite),
    .addr (dataAdr),
    .wd   (writeData),
    .rd   (readData)
  );

endmodule

// ==== dataMem.sv ====
/*
 * Data memory: word-addressed RAM, combinational read, clocked write
 */
module dataMem (
  input  logic                     clk,
  input  logic                     we,
  input  logic [armPkg::wordW-1:0] addr,
  input  logic [armPkg::wordW-1:0] wd,
  output logic [armPkg::wordW-1:0] rd
);
  import armPkg::*;

  logic [wordW-1:0] mem [0:dmemWords-1];

  // Byte offset bits dropped, upper bits beyond the depth ignored
  assign rd = mem[addr[$clog2(dmemWords)+1:2]];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr[$clog2(dmemWords)+1:2]] <= wd;
    end
  end

endmodule

// ==== armDatapath.sv ====
/*
 * Datapath: PC register, immediate extension, operand and result muxing
 * around the register file and ALU
 */
module armDatapath (
  input  logic                     clk,
  input  logic                     reset,
  input  armPkg::instrT            instr,
  input  armPkg::ctrlT             ctrl,
  input  logic                     regWriteEn,
  input  logic                     pcSrc,
  input  logic                     movSel,
  input  logic [armPkg::wordW-1:0] readData,
  output logic [armPkg::wordW-1:0] pc,
  output logic [armPkg::wordW-1:0] aluResult,
  output logic [armPkg::wordW-1:0] writeData,
  output armPkg::flagsT            aluFlags
);
  import armPkg::*;

  logic [wordW-1:0] pcNext;
  logic [wordW-1:0] pcPlus4;
  logic [wordW-1:0] pcPlus8;
  logic [wordW-1:0] extImm;
  logic [wordW-1:0] regA;
  logic [wordW-1:0] srcA;
  logic [wordW-1:0] srcB;
  logic [wordW-1:0] result;
  logic [3:0]       ra1;
  logic [3:0]       ra2;

  // Next PC
  assign pcPlus4 = pc + wordW'(instrBytes);
  assign pcPlus8 = pcPlus4 + wordW'(instrBytes);
  assign pcNext  = pcSrc ? result : pcPlus4;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

  // Branches read R15 on port A, stores read rd on port B
  assign ra1 = ctrl.readPcAsA ? 4'(pcReg) : instr.rn;
  assign ra2 = ctrl.readRdAsB ? instr.rd : instr.imm12[3:0];

  regFile regFile_inst (
    .clk     (clk),
    .we      (regWriteEn),
    .ra1     (ra1),
    .ra2     (ra2),
    .wa      (instr.rd),
    .wd      (result),
    .pcPlus8 (pcPlus8),
    .rd1     (regA),
    .rd2     (writeData)
  );

  always_comb begin
    case (ctrl.immSrc)
      immData8:    extImm = wordW'(instr.imm12[7:0]);
      immMem12:    extImm = wordW'(instr.imm12);
      immBranch24: extImm = {{(wordW - 26){instr[23]}}, instr[23:0], 2'b00};
      default:     extImm = '0;
    endcase
  end

  // MOV passes B through the adder so MOVS sees its own N and Z
  assign srcA = ctrl.movResult ? '0 : regA;
  assign srcB = ctrl.useImm ? extImm : writeData;

  armAlu armAlu_inst (
    .a      (srcA),
    .b      (srcB),
    .aluOp  (ctrl.aluOp),
    .result (aluResult),
    .flags  (aluFlags)
  );

  assign result = ctrl.memToReg ? readData : (movSel ? srcB : aluResult);

endmodule

// ==== condUnit.sv ====
/*
 * Condition unit: holds NZCV, evaluates the condition field and gates
 * every architectural side effect of the current instruction
 */
module condUnit (
  input  logic           clk,
  input  logic           reset,
  input  armPkg::condT   cond,
  input  armPkg::ctrlT   ctrl,
  input  armPkg::flagsT  aluFlags,
  output logic           regWriteEn,
  output logic           memWriteEn,
  output logic           pcSrc,
  output logic           movSel
);
  import armPkg::*;

  flagsT flags;
  logic  condEx;
  logic  ge;

  // N and Z half
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flags.neg  <= 1'b0;
      flags.zero <= 1'b0;
    end else if (ctrl.flagWriteNz && condEx) begin
      flags.neg  <= aluFlags.neg;
      flags.zero <= aluFlags.zero;
    end
  end

  // C and V half, arithmetic only
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flags.carry    <= 1'b0;
      flags.overflow <= 1'b0;
    end else if (ctrl.flagWriteCv && condEx) begin
      flags.carry    <= aluFlags.carry;
      flags.overflow <= aluFlags.overflow;
    end
  end

  assign ge = (flags.neg == flags.overflow);

  always_comb begin
    case (cond)
      condEq:  condEx = flags.zero;
      condNe:  condEx = ~flags.zero;
      condCs:  condEx = flags.carry;
      condCc:  condEx = ~flags.carry;
      condMi:  condEx = flags.neg;
      condPl:  condEx = ~flags.neg;
      condVs:  condEx = flags.overflow;
      condVc:  condEx = ~flags.overflow;
      condHi:  condEx = flags.carry & ~flags.zero;
      condLs:  condEx = ~flags.carry | flags.zero;
      condGe:  condEx = ge;
      condLt:  condEx = ~ge;
      condGt:  condEx = ~flags.zero & ge;
      condLe:  condEx = flags.zero | ~ge;
      condAl:  condEx = 1'b1;
      default: condEx = 1'b0;  // 1111 treated as never
    endcase
  end

  assign regWriteEn = ctrl.regWrite & condEx & ~ctrl.noWrite;
  assign memWriteEn = ctrl.memWrite & condEx;
  assign pcSrc      = ctrl.pcWrite & condEx;
  assign movSel     = ctrl.movResult & condEx;

endmodule

// ==== armDecoder.sv ====
/*
 * Instruction decoder: main decoder for class-level controls plus an ALU
 * decoder for data-processing opcodes, producing one control word
 */
module armDecoder (
  input  armPkg::opClassT op,
  input  logic [5:0]      funct,
  input  logic [3:0]      rd,
  output armPkg::ctrlT    ctrl
);
  import armPkg::*;

  dpOpT dpOp;
  logic isBranch;
  logic isArith;

  assign dpOp = dpOpT'(funct[4:1]);

  always_comb begin
    ctrl     = '0;
    isBranch = 1'b0;
    isArith  = 1'b0;
    case (op)
      opData: begin
        // funct[5] is the I bit, funct[0] the S bit
        ctrl.useImm   = funct[5];
        ctrl.immSrc   = immData8;
        ctrl.regWrite = 1'b1;
        case (dpOp)
          dpAdd: begin
            ctrl.aluOp = aluAdd;
            isArith    = 1'b1;
          end
          dpSub: begin
            ctrl.aluOp = aluSub;
            isArith    = 1'b1;
          end
          dpCmp: begin
            // Subtract for flags only
            ctrl.aluOp   = aluSub;
            ctrl.noWrite = 1'b1;
            isArith      = 1'b1;
          end
          dpAnd: ctrl.aluOp = aluAnd;
          dpOrr: ctrl.aluOp = aluOrr;
          dpEor: ctrl.aluOp = aluEor;
          dpMov: begin
            ctrl.aluOp     = aluAdd;
            ctrl.movResult = 1'b1;
          end
          default: ctrl.regWrite = 1'b0;
        endcase
        ctrl.flagWriteNz = funct[0];
        ctrl.flagWriteCv = funct[0] & isArith;
      end
      opMem: begin
        // funct[0] is L; STR needs rd on the second read port
        ctrl.useImm    = 1'b1;
        ctrl.immSrc    = immMem12;
        ctrl.aluOp     = aluAdd;
        ctrl.memToReg  = funct[0];
        ctrl.regWrite  = funct[0];
        ctrl.memWrite  = ~funct[0];
        ctrl.readRdAsB = ~funct[0];
      end
      opBranch: begin
        // Target is PC+8 plus the shifted offset
        ctrl.readPcAsA = 1'b1;
        ctrl.useImm    = 1'b1;
        ctrl.immSrc    = immBranch24;
        ctrl.aluOp     = aluAdd;
        isBranch       = 1'b1;
      end
      default: ctrl = '0;
    endcase
    ctrl.pcWrite = isBranch | (ctrl.regWrite & (rd == 4'(pcReg)));
  end

endmodule

// ==== regFile.sv ====
/*
 * Register file: R0-R14 in storage, two combinational reads, one write;
 * R15 reads back as PC+8
 */
module regFile (
  input  logic                     clk,
  input  logic                     we,
  input  logic [3:0]               ra1,
  input  logic [3:0]               ra2,
  input  logic [3:0]               wa,
  input  logic [armPkg::wordW-1:0] wd,
  input  logic [armPkg::wordW-1:0] pcPlus8,
  output logic [armPkg::wordW-1:0] rd1,
  output logic [armPkg::wordW-1:0] rd2
);
  import armPkg::*;

  logic [wordW-1:0] regs [0:regCount-2];

  // R15 writes go to the PC instead
  always_ff @(posedge clk) begin
    if (we && (wa != 4'(pcReg))) begin
      regs[wa] <= wd;
    end
  end

  assign rd1 = (ra1 == 4'(pcReg)) ? pcPlus8 : regs[ra1];
  assign rd2 = (ra2 == 4'(pcReg)) ? pcPlus8 : regs[ra2];

endmodule

// ==== armAlu.sv ====
/*
 * ALU: add, subtract, AND, ORR, EOR with NZCV generation
 */
module armAlu (
  input  logic [armPkg::wordW-1:0] a,
  input  logic [armPkg::wordW-1:0] b,
  input  armPkg::aluOpT            aluOp,
  output logic [armPkg::wordW-1:0] result,
  output armPkg::flagsT            flags
);
  import armPkg::*;

  logic             isSub;
  logic             isArith;
  logic [wordW-1:0] bIn;
  logic [wordW:0]   sum;

  assign isSub   = (aluOp == aluSub);
  assign isArith = (aluOp == aluAdd) || isSub;

  // Subtract as a + ~b + 1, carry out is the ARM "no borrow"
  assign bIn = isSub ? ~b : b;
  assign sum = {1'b0, a} + {1'b0, bIn} + (wordW + 1)'(isSub);

  always_comb begin
    case (aluOp)
      aluAdd, aluSub: result = sum[wordW-1:0];
      aluAnd:         result = a & b;
      aluOrr:         result = a | b;
      aluEor:         result = a ^ b;
      default:        result = '0;
    endcase
  end

  assign flags.neg   = result[wordW-1];
  assign flags.zero  = (result == '0);
  assign flags.carry = isArith & sum[wordW];
  // Operands of equal sign after inversion, result sign differs
  assign flags.overflow = isArith
                        & ~(a[wordW-1] ^ b[wordW-1] ^ isSub)
                        & (a[wordW-1] ^ sum[wordW-1]);

endmodule

// ==== armPkg.sv ====
/*
 * ARM single-cycle core shared definitions: widths, instruction layout,
 * opcode/condition/ALU enums and the control and flag structs
 */
package armPkg;

  localparam int wordW      = 32;
  localparam int regCount   = 16;
  localparam int pcReg      = 15;
  localparam int dmemWords  = 64;
  localparam int instrBytes = 4;

  // Instruction class in bits 27:26
  typedef enum logic [1:0] {
    opData   = 2'b00,
    opMem    = 2'b01,
    opBranch = 2'b10
  } opClassT;

  // Data-processing opcodes, funct[4:1]
  typedef enum logic [3:0] {
    dpAnd = 4'b0000,
    dpEor = 4'b0001,
    dpSub = 4'b0010,
    dpAdd = 4'b0100,
    dpCmp = 4'b1010,
    dpOrr = 4'b1100,
    dpMov = 4'b1101
  } dpOpT;

  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc,
    condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt,
    condGt, condLe, condAl
  } condT;

  typedef enum logic [2:0] {
    aluAdd, aluSub, aluAnd, aluOrr, aluEor
  } aluOpT;

  typedef enum logic [1:0] {
    immData8, immMem12, immBranch24
  } immSrcT;

  // Low nibble of imm12 doubles as rm for register operands
  typedef struct packed {
    condT        cond;
    opClassT     op;
    logic [5:0]  funct;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] imm12;
  } instrT;

  typedef struct packed {
    logic neg;
    logic zero;
    logic carry;
    logic overflow;
  } flagsT;

  // Unconditional decoder output, gated later by the condition unit
  typedef struct packed {
    logic   readRdAsB;
    logic   readPcAsA;
    immSrcT immSrc;
    logic   useImm;
    logic   memToReg;
    logic   regWrite;
    logic   memWrite;
    logic   pcWrite;
    logic   flagWriteNz;
    logic   flagWriteCv;
    logic   noWrite;
    logic   movResult;
    aluOpT  aluOp;
  } ctrlT;

endpackage
